// File: rtl/mmc5_map_pkg.sv
// CPU address map of the mapper as seen from $5000 to $FFFF with PRG RAM limited to eight 8 KB pages
package mmc5_map_pkg;

	// Register window at $5000-$53FF
	localparam logic [5:0] REG_WIN_BASE = 6'b01_0100; // Matched against prg_ain[15:10]

	// Register offsets inside the window
	localparam logic [9:0] REG_PRG_MODE     = 10'h100; // $5100 PRG banking mode
	localparam logic [9:0] REG_PROTECT_1    = 10'h102; // $5102 first RAM unlock
	localparam logic [9:0] REG_PROTECT_2    = 10'h103; // $5103 second RAM unlock
	localparam logic [9:0] REG_EXRAM_MODE   = 10'h104; // $5104
	localparam logic [9:0] REG_PRG_RAM_BANK = 10'h113; // $5113 bank for $6000-$7FFF
	localparam logic [9:0] REG_PRG_BANK_0   = 10'h114;
	localparam logic [9:0] REG_PRG_BANK_1   = 10'h115;
	localparam logic [9:0] REG_PRG_BANK_2   = 10'h116;
	localparam logic [9:0] REG_PRG_BANK_3   = 10'h117; // ROM only
	localparam logic [9:0] REG_MULT_A       = 10'h205; // Write operand and read product low
	localparam logic [9:0] REG_MULT_B       = 10'h206; // Write operand and read product high

	// Expansion RAM window at $5C00-$5FFF
	localparam logic [5:0] EXRAM_WIN_BASE = 6'b01_0111;

	// Start of PRG space
	localparam logic [15:0] PRG_RAM_BASE = 16'h6000;

	// Upper address bits of PRG RAM in the 22-bit space
	// ROM occupies the low 1 MB so saves sit well clear of it
	localparam logic [5:0] PRG_RAM_PAGE = 6'b11_1100;

	// Unlock values for the two protect registers
	localparam logic [1:0] PROTECT_1_KEY = 2'b10;
	localparam logic [1:0] PROTECT_2_KEY = 2'b01;

endpackage

// File: rtl/mmc5_cfg_pkg.sv
// Mapper configuration types and widths shared by the register file and its readers
package mmc5_cfg_pkg;

	localparam int PRG_BANK_W = 8;  // Full selector byte
	localparam int ROM_BANK_W = 7;  // 128 ROM banks of 8 KB
	localparam int RAM_BANK_W = 3;  // 8 RAM banks of 8 KB
	localparam int EXRAM_AW   = 10; // 1 KB expansion RAM

	// PRG banking modes as written to $5100
	typedef enum logic [1:0] {
		PRG_32K    = 2'd0,
		PRG_16K    = 2'd1,
		PRG_16K_8K = 2'd2, // 16K at $8000 then two 8K banks
		PRG_8K     = 2'd3
	} prg_mode_t;

	// Expansion RAM use as written to $5104
	// Upper bit set means the CPU may read it
	typedef enum logic [1:0] {
		EXRAM_NT     = 2'd0,
		EXRAM_EXATTR = 2'd1,
		EXRAM_RAM    = 2'd2,
		EXRAM_ROM    = 2'd3  // Read only
	} exram_mode_t;

	// Selector byte with bit 7 choosing ROM or RAM
	typedef union packed {
		struct packed {
			logic                  is_rom;
			logic [ROM_BANK_W-1:0] bank;
		} rom;
		struct packed {
			logic                               is_rom;
			logic [PRG_BANK_W-RAM_BANK_W-2:0]   unused; // Ignored for RAM
			logic [RAM_BANK_W-1:0]              bank;
		} ram;
	} prg_sel_u;

endpackage

// File: rtl/mmc5_cfg_if.sv
// Configuration bundle with one writer, the register file, and read-only users elsewhere
`timescale 1ns/1ps

interface mmc5_cfg_if;
	import mmc5_cfg_pkg::*;

	prg_mode_t             prg_mode;
	logic [RAM_BANK_W-1:0] prg_ram_bank;
	logic [PRG_BANK_W-1:0] prg_bank [4]; // Bank 3 always reads back with bit 7 set
	logic                  ram_we;       // Both unlock keys present
	exram_mode_t           exram_mode;
	logic [7:0]            mult_a;
	logic [7:0]            mult_b;

	modport src (
		output prg_mode, prg_ram_bank, prg_bank, ram_we,
		output exram_mode, mult_a, mult_b
	);

	modport dst (
		input prg_mode, prg_ram_bank, prg_bank, ram_we,
		input exram_mode, mult_a, mult_b
	);

endinterface

// File: rtl/mmc5_reg_file.sv
// Registers load on a CPU write strobe in $5000-$53FF and unknown offsets are ignored
`timescale 1ns/1ps

module mmc5_reg_file (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        ce,        // CPU cycle strobe
	input  logic        prg_write,
	input  logic [15:0] prg_ain,
	input  logic [7:0]  prg_din,
	mmc5_cfg_if.src     cfg
);
	import mmc5_map_pkg::*;
	import mmc5_cfg_pkg::*;

	prg_mode_t                   prg_mode_q;
	logic                        protect_1_q;  // Key 1 matched
	logic                        protect_2_q;  // Key 2 matched
	exram_mode_t                 exram_mode_q;
	logic [RAM_BANK_W-1:0]       prg_ram_bank_q;
	logic [2:0][PRG_BANK_W-1:0]  prg_bank_q;   // Banks 0 to 2 keep the RAM flag
	logic [ROM_BANK_W-1:0]       prg_bank3_q;  // Bank 3 has no RAM flag
	logic [7:0]                  mult_a_q;
	logic [7:0]                  mult_b_q;
	logic                        reg_wr;       // Write strobe into the register window

	assign reg_wr = ce && prg_write && (prg_ain[15:10] == REG_WIN_BASE);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prg_mode_q     <= PRG_8K;           // Boot vectors come from the last bank
			protect_1_q    <= 1'b0;
			protect_2_q    <= 1'b0;
			exram_mode_q   <= EXRAM_NT;
			prg_ram_bank_q <= '0;
			prg_bank_q     <= '0;
			prg_bank3_q    <= '1;               // 7'h7F
			mult_a_q       <= '0;
			mult_b_q       <= '0;
		end else if (reg_wr) begin
			case (prg_ain[9:0])
				REG_PRG_MODE:     prg_mode_q     <= prg_mode_t'(prg_din[1:0]);
				REG_PROTECT_1:    protect_1_q    <= (prg_din[1:0] == PROTECT_1_KEY);
				REG_PROTECT_2:    protect_2_q    <= (prg_din[1:0] == PROTECT_2_KEY);
				REG_EXRAM_MODE:   exram_mode_q   <= exram_mode_t'(prg_din[1:0]);
				REG_PRG_RAM_BANK: prg_ram_bank_q <= prg_din[RAM_BANK_W-1:0];
				REG_PRG_BANK_0:   prg_bank_q[0]  <= prg_din;
				REG_PRG_BANK_1:   prg_bank_q[1]  <= prg_din;
				REG_PRG_BANK_2:   prg_bank_q[2]  <= prg_din;
				REG_PRG_BANK_3:   prg_bank3_q    <= prg_din[ROM_BANK_W-1:0];
				REG_MULT_A:       mult_a_q       <= prg_din;
				REG_MULT_B:       mult_b_q       <= prg_din;
				default: ;                          // Unused offsets ignored
			endcase
		end
	end

	assign cfg.prg_mode     = prg_mode_q;
	assign cfg.prg_ram_bank = prg_ram_bank_q;
	assign cfg.prg_bank[0]  = prg_bank_q[0];
	assign cfg.prg_bank[1]  = prg_bank_q[1];
	assign cfg.prg_bank[2]  = prg_bank_q[2];
	assign cfg.prg_bank[3]  = {1'b1, prg_bank3_q}; // Top region always maps to ROM
	assign cfg.exram_mode   = exram_mode_q;
	assign cfg.mult_a       = mult_a_q;
	assign cfg.mult_b       = mult_b_q;

	// RAM writes need both keys at once
	assign cfg.ram_we = protect_1_q && protect_2_q;

	// Configuration only moves on a CPU write cycle
	a_cfg_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!(ce && prg_write) |=> $stable({prg_mode_q, protect_1_q, protect_2_q, exram_mode_q,
			prg_ram_bank_q, prg_bank_q, prg_bank3_q, mult_a_q, mult_b_q}))
		else $error("configuration changed without a CPU write");

endmodule

// File: rtl/mmc5_exram.sv
// CPU port of the 1 KB expansion RAM only with one cycle read latency and no PPU access
`timescale 1ns/1ps

module mmc5_exram (
	input  logic        clk,
	input  logic        ce,        // CPU cycle strobe
	input  logic        prg_write,
	input  logic [15:0] prg_ain,
	input  logic [7:0]  prg_din,
	mmc5_cfg_if.dst     cfg,
	output logic [7:0]  rd_data,   // Byte at the address of the previous edge
	output logic        rd_sel     // Address in window and mode readable
);
	import mmc5_map_pkg::*;
	import mmc5_cfg_pkg::*;

	logic [7:0] mem [0:(1<<EXRAM_AW)-1]; // Block RAM
	logic       win_hit;                 // $5C00-$5FFF
	logic       mem_we;
	logic [7:0] wr_byte;

	assign win_hit = (prg_ain[15:10] == EXRAM_WIN_BASE);

	// ROM mode blocks CPU writes entirely
	assign mem_we = ce && prg_write && win_hit && (cfg.exram_mode != EXRAM_ROM);

	// Without a PPU frame the nametable and exattr modes always store zero
	assign wr_byte = cfg.exram_mode[1] ? prg_din : 8'h00;

	always_ff @(posedge clk) begin
		if (mem_we)
			mem[prg_ain[EXRAM_AW-1:0]] <= wr_byte;
		rd_data <= mem[prg_ain[EXRAM_AW-1:0]]; // Read before write on the same edge
	end

	assign rd_sel = win_hit && cfg.exram_mode[1]; // Modes 2 and 3 are readable

	// A blocked ROM mode write leaves the addressed byte unchanged after the edge
	a_rom_hold: assert property (@(posedge clk)
		(ce && prg_write && win_hit && cfg.exram_mode == EXRAM_ROM)
		|=> (mem[$past(prg_ain[EXRAM_AW-1:0])] === $past(mem[prg_ain[EXRAM_AW-1:0]])))
		else $error("expansion RAM written in ROM mode");

endmodule

// File: rtl/mmc5_prg_port.sv
// Combinational PRG translation and read mux where only expansion RAM data arrives a clock late
`timescale 1ns/1ps

module mmc5_prg_port (
	input  logic [15:0] prg_ain,
	input  logic        prg_write,
	mmc5_cfg_if.dst     cfg,
	input  logic [7:0]  rd_data,   // Expansion RAM byte
	input  logic        rd_sel,    // Expansion RAM owns the read
	output logic [21:0] prg_aout,  // 8 KB bank plus offset
	output logic        prg_allow,
	output logic [7:0]  prg_dout
);
	import mmc5_map_pkg::*;
	import mmc5_cfg_pkg::*;

	prg_sel_u    sel;        // Bank selector for the current 8 KB slot
	logic        above_base; // $6000 and up
	logic [15:0] product;

	// Bank table per mode
	always_comb begin
		sel = '0;
		if (!prg_ain[15]) begin
			sel.ram.is_rom = 1'b0;             // $6000-$7FFF in every mode
			sel.ram.bank   = cfg.prg_ram_bank;
		end else begin
			case (cfg.prg_mode)
				PRG_32K: sel = {cfg.prg_bank[3][PRG_BANK_W-1:2], prg_ain[14:13]};
				PRG_16K: begin
					if (prg_ain[14])
						sel = {cfg.prg_bank[3][PRG_BANK_W-1:1], prg_ain[13]};
					else
						sel = {cfg.prg_bank[1][PRG_BANK_W-1:1], prg_ain[13]};
				end
				PRG_16K_8K: begin
					case (prg_ain[14:13])
						2'b10:   sel = cfg.prg_bank[2];                         // $C000
						2'b11:   sel = cfg.prg_bank[3];                         // $E000
						default: sel = {cfg.prg_bank[1][PRG_BANK_W-1:1], prg_ain[13]};
					endcase
				end
				PRG_8K: sel = cfg.prg_bank[prg_ain[14:13]]; // One register per slot
			endcase
		end
	end

	assign above_base = (prg_ain >= PRG_RAM_BASE);
	assign product    = {8'h00, cfg.mult_a} * {8'h00, cfg.mult_b};

	always_comb begin
		if (sel.rom.is_rom)
			prg_aout = {2'b00, sel.rom.bank, prg_ain[12:0]};
		else
			prg_aout = {PRG_RAM_PAGE, sel.ram.bank, prg_ain[12:0]};

		// Reads always pass and writes only reach unlocked RAM
		prg_allow = above_base && (!prg_write || (!sel.ram.is_rom && cfg.ram_we));

		// Open bus unless something claims the address
		if (rd_sel)
			prg_dout = rd_data;
		else if (prg_ain == {REG_WIN_BASE, REG_MULT_A})
			prg_dout = product[7:0];
		else if (prg_ain == {REG_WIN_BASE, REG_MULT_B})
			prg_dout = product[15:8];
		else
			prg_dout = 8'hFF;

		// Upper address bits alone place the access in $6000-$FFFF
		a_allow_range: assert (!prg_allow || prg_ain[15] || (prg_ain[14:13] == 2'b11))
			else $error("access allowed below $6000");
		a_write_ram: assert (!(prg_allow && prg_write) || prg_aout[21:16] == PRG_RAM_PAGE)
			else $error("allowed write outside the PRG RAM page");
	end

endmodule

// File: rtl/mmc5.sv
// CPU side only with no PPU, IRQ or audio and outputs driven at all times
`timescale 1ns/1ps

module mmc5 (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        ce,        // CPU cycle strobe
	input  logic [15:0] prg_ain,
	input  logic        prg_write,
	input  logic [7:0]  prg_din,
	output logic [7:0]  prg_dout,
	output logic [21:0] prg_aout,
	output logic        prg_allow
);

	logic [7:0] exram_rd_data;
	logic       exram_rd_sel;

	mmc5_cfg_if cfg ();

	mmc5_reg_file i_reg_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.ce        (ce),
		.prg_write (prg_write),
		.prg_ain   (prg_ain),
		.prg_din   (prg_din),
		.cfg       (cfg.src)
	);

	mmc5_exram i_exram (
		.clk       (clk),
		.ce        (ce),
		.prg_write (prg_write),
		.prg_ain   (prg_ain),
		.prg_din   (prg_din),
		.cfg       (cfg.dst),
		.rd_data   (exram_rd_data),
		.rd_sel    (exram_rd_sel)
	);

	mmc5_prg_port i_prg_port (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.cfg       (cfg.dst),
		.rd_data   (exram_rd_data),
		.rd_sel    (exram_rd_sel),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.prg_dout  (prg_dout)
	);

endmodule

// File: bench/mmc5_tb_model.svh
// Reference model included inside the testbench after the package imports and only read back where written
`ifndef MMC5_TB_MODEL_SVH
`define MMC5_TB_MODEL_SVH

logic [1:0] m_prg_mode;          // $5100
logic [2:0] m_ram_bank;          // $5113
logic [7:0] m_bank [4];          // Bank 3 kept with its ROM flag set
logic       m_key1;              // $5102 matched its key
logic       m_key2;
logic [1:0] m_exram_mode;        // $5104
logic [7:0] m_mult_a;
logic [7:0] m_mult_b;
logic [7:0] shadow_exram [1024]; // Mirror of the expansion RAM

// Power-on state of the mapper
task automatic model_reset();
	m_prg_mode   = 2'd3;  // 8K mode
	m_ram_bank   = '0;
	m_bank[0]    = '0;
	m_bank[1]    = '0;
	m_bank[2]    = '0;
	m_bank[3]    = 8'hFF; // ROM bank 7F
	m_key1       = 1'b0;
	m_key2       = 1'b0;
	m_exram_mode = 2'd0;  // Nametable
	m_mult_a     = '0;
	m_mult_b     = '0;
endtask

// Applies one CPU write to the model
task automatic track_write(input logic [15:0] a, input logic [7:0] d);
	if (a[15:10] == REG_WIN_BASE) begin
		case (a[9:0])
			REG_PRG_MODE:     m_prg_mode = d[1:0];
			REG_PROTECT_1:    m_key1 = (d[1:0] == PROTECT_1_KEY);
			REG_PROTECT_2:    m_key2 = (d[1:0] == PROTECT_2_KEY);
			REG_EXRAM_MODE:   m_exram_mode = d[1:0];
			REG_PRG_RAM_BANK: m_ram_bank = d[2:0];
			REG_PRG_BANK_0:   m_bank[0] = d;
			REG_PRG_BANK_1:   m_bank[1] = d;
			REG_PRG_BANK_2:   m_bank[2] = d;
			REG_PRG_BANK_3:   m_bank[3] = {1'b1, d[6:0]}; // Top slot never holds RAM
			REG_MULT_A:       m_mult_a = d;
			REG_MULT_B:       m_mult_b = d;
			default: ;
		endcase
	end else if (a[15:10] == EXRAM_WIN_BASE && m_exram_mode != 2'd3) begin
		shadow_exram[a[9:0]] = m_exram_mode[1] ? d : 8'h00; // Nametable and exattr store zero
	end
endtask

// Selector byte for the 8 KB slot holding the address
function automatic logic [7:0] slot_selector(input logic [15:0] a);
	logic [1:0] slot;
	logic [7:0] sel;
	slot = a[14:13];
	if (!a[15])
		sel = {5'b00000, m_ram_bank}; // $6000-$7FFF is always the RAM bank
	else if (m_prg_mode == 2'd0)
		sel = {m_bank[3][7:2], slot}; // One 32K bank
	else if (m_prg_mode == 2'd1)
		sel = slot[1] ? {m_bank[3][7:1], slot[0]} : {m_bank[1][7:1], slot[0]};
	else if (m_prg_mode == 2'd2 && !slot[1])
		sel = {m_bank[1][7:1], slot[0]}; // 16K half at $8000
	else
		sel = m_bank[slot];
	return sel;
endfunction

function automatic logic [21:0] ref_prg_aout(input logic [15:0] a);
	logic [7:0] sel;
	sel = slot_selector(a);
	if (sel[7])
		return {2'b00, sel[6:0], a[12:0]};
	return {PRG_RAM_PAGE, sel[2:0], a[12:0]};
endfunction

function automatic logic ref_prg_allow(input logic [15:0] a, input logic wr);
	logic [7:0] sel;
	sel = slot_selector(a);
	return (a >= PRG_RAM_BASE) && (!wr || (!sel[7] && m_key1 && m_key2));
endfunction

// Shift and add product
function automatic logic [15:0] ref_product(input logic [7:0] a, input logic [7:0] b);
	logic [15:0] acc;
	acc = '0;
	for (int i = 0; i < 8; i++)
		if (b[i])
			acc = acc + (16'(a) << i);
	return acc;
endfunction

function automatic logic [7:0] expected_dout(input logic [15:0] a);
	logic [15:0] p;
	p = ref_product(m_mult_a, m_mult_b);
	if (a[15:10] == EXRAM_WIN_BASE && m_exram_mode[1])
		return shadow_exram[a[9:0]]; // RAM and ROM modes readable
	if (a == {REG_WIN_BASE, REG_MULT_A})
		return p[7:0];
	if (a == {REG_WIN_BASE, REG_MULT_B})
		return p[15:8];
	return 8'hFF; // Open bus
endfunction

`endif

// File: bench/mmc5_tb.sv
// Self-checking testbench with a fixed seed where expansion RAM is only compared at written addresses
`timescale 1ns/1ps

module mmc5_tb;
	import mmc5_map_pkg::*;
	import mmc5_cfg_pkg::*;

	localparam int RESET_LEN = 64;           // Cycles per test, upper bounds
	localparam int XLATE_LEN = 4 * (8 + 200);
	localparam int PROT_LEN  = 64;
	localparam int EXRAM_LEN = 200;
	localparam int MULT_LEN  = 64;
	localparam int TEST_LEN  = 8 + RESET_LEN + XLATE_LEN + PROT_LEN + EXRAM_LEN + MULT_LEN;
	localparam int LIMIT     = 2 * TEST_LEN;
	localparam logic [2:0] CHK_AOUT  = 3'b001;
	localparam logic [2:0] CHK_ALLOW = 3'b010;
	localparam logic [2:0] CHK_DOUT  = 3'b100;

	logic        clk;
	logic        arst_n;
	logic        ce;
	logic [15:0] prg_ain;
	logic        prg_write;
	logic [7:0]  prg_din;
	logic [7:0]  prg_dout;
	logic [21:0] prg_aout;
	logic        prg_allow;

	logic [2:0]  chk_mask;      // Outputs compared for the current cycle
	logic [21:0] exp_aout;
	logic        exp_allow;
	logic [7:0]  exp_dout;
	string       chk_name;
	string       test_name;
	logic [31:0] rng_state;
	logic [15:0] ex_addr [16];  // Expansion RAM addresses reused across modes
	int          errors;
	int          checks;
	int          cycle_count;

	`include "mmc5_tb_model.svh"

	mmc5 i_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.prg_dout  (prg_dout),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// One CPU cycle, expectations taken before the model sees the write
	task automatic bus_cycle(input logic [15:0] a, input logic wr, input logic [7:0] d,
		input logic [2:0] mask);
		@(posedge clk);
		prg_ain   <= a;
		prg_write <= wr;
		prg_din   <= d;
		chk_mask  <= mask;
		chk_name  <= test_name;
		exp_aout  <= ref_prg_aout(a);
		exp_allow <= ref_prg_allow(a, wr);
		exp_dout  <= expected_dout(a);
		if (wr)
			track_write(a, d);
	endtask

	task automatic write_reg(input logic [9:0] off, input logic [7:0] d);
		bus_cycle({REG_WIN_BASE, off}, 1'b1, d, CHK_ALLOW);
	endtask

	// Address held two edges for the registered read
	task automatic read_exram(input logic [15:0] a);
		bus_cycle(a, 1'b0, 8'h00, 3'b000);
		bus_cycle(a, 1'b0, 8'h00, CHK_DOUT);
	endtask

	task automatic verify_reset_state();
		int i;
		logic [31:0] r;
		test_name = "reset_defaults";
		for (i = 0; i < 16; i++) begin
			r = next_random();
			bus_cycle({3'b111, r[12:0]}, 1'b0, 8'h00, CHK_AOUT | CHK_ALLOW); // Bank 7F
		end
		for (i = 0; i < 8; i++) begin
			r = next_random();
			read_exram({EXRAM_WIN_BASE, r[9:0]});
		end
		for (i = 0; i < 8; i++) begin
			r = next_random();
			bus_cycle({4'b0100, r[11:0]}, 1'b0, 8'h00, CHK_DOUT | CHK_ALLOW); // Unmapped
		end
	endtask

	task automatic sweep_prg_modes();
		int m;
		int i;
		logic [31:0] r;
		test_name = "prg_translation";
		for (m = 0; m < 4; m++) begin
			write_reg(REG_PRG_MODE, 8'(m));
			r = next_random();
			write_reg(REG_PRG_RAM_BANK, r[7:0]);
			write_reg(REG_PRG_BANK_0, r[15:8]);
			write_reg(REG_PRG_BANK_1, r[23:16]);
			write_reg(REG_PRG_BANK_2, r[31:24]);
			r = next_random();
			write_reg(REG_PRG_BANK_3, r[7:0]);
			for (i = 0; i < 200; i++) begin
				r = next_random();
				bus_cycle(PRG_RAM_BASE + 16'(r % 32'h0000A000), 1'b0, 8'h00,
					CHK_AOUT | CHK_ALLOW);
			end
		end
	endtask

	// Writes spread over RAM, a ROM slot at $8000 and the top slot
	task automatic try_writes(input int n);
		int i;
		logic [31:0] r;
		logic [15:0] a;
		for (i = 0; i < n; i++) begin
			r = next_random();
			case (r[31:30])
				2'd0, 2'd1: a = {3'b011, r[12:0]};
				2'd2:       a = {3'b100, r[12:0]};
				default:    a = {3'b111, r[12:0]};
			endcase
			bus_cycle(a, 1'b1, r[23:16], CHK_AOUT | CHK_ALLOW);
		end
	endtask

	task automatic exercise_protection();
		test_name = "write_protect";
		write_reg(REG_PRG_MODE, 8'h03);
		write_reg(REG_PRG_BANK_0, 8'h85);
		try_writes(6);                    // Locked
		write_reg(REG_PROTECT_1, 8'h02);
		try_writes(6);                    // One key only
		write_reg(REG_PROTECT_2, 8'h01);
		try_writes(12);                   // Unlocked
		write_reg(REG_PROTECT_1, 8'h03);
		try_writes(6);                    // Wrong key locks again
	endtask

	task automatic exram_pass(input string name, input logic [7:0] mode, input bit do_write);
		int i;
		logic [31:0] r;
		test_name = name;
		write_reg(REG_EXRAM_MODE, mode);
		for (i = 0; i < 16 && do_write; i++) begin
			r = next_random();
			bus_cycle(ex_addr[i], 1'b1, r[7:0], 3'b000);
		end
		for (i = 0; i < 16; i++)
			read_exram(ex_addr[i]);
	endtask

	task automatic cycle_exram_modes();
		int i;
		logic [31:0] r;
		for (i = 0; i < 16; i++) begin
			r = next_random();
			ex_addr[i] = {EXRAM_WIN_BASE, r[9:0]};
		end
		exram_pass("exram_ram", 8'h02, 1'b1);
		exram_pass("exram_rom", 8'h03, 1'b1);       // Writes blocked
		exram_pass("exram_nametable", 8'h00, 1'b1); // Stores zero, reads open bus
		exram_pass("exram_zeros", 8'h02, 1'b0);
	endtask

	task automatic multiply_pairs();
		int i;
		logic [31:0] r;
		test_name = "multiplier";
		for (i = 0; i < 16; i++) begin
			r = next_random();
			write_reg(REG_MULT_A, r[7:0]);
			write_reg(REG_MULT_B, r[15:8]);
			bus_cycle({REG_WIN_BASE, REG_MULT_A}, 1'b0, 8'h00, CHK_DOUT);
			bus_cycle({REG_WIN_BASE, REG_MULT_B}, 1'b0, 8'h00, CHK_DOUT);
		end
	endtask

	// Compare at the falling edge where inputs and outputs have settled
	always @(negedge clk) begin
		if (arst_n && chk_mask != 3'b000) begin
			checks = checks + 1;
			if (chk_mask[0] && prg_aout !== exp_aout) begin
				errors = errors + 1;
				$display("[FAIL] %s prg_aout expected %h actual %h", chk_name, exp_aout, prg_aout);
			end
			if (chk_mask[1] && prg_allow !== exp_allow) begin
				errors = errors + 1;
				$display("[FAIL] %s prg_allow expected %b actual %b", chk_name, exp_allow,
					prg_allow);
			end
			if (chk_mask[2] && prg_dout !== exp_dout) begin
				errors = errors + 1;
				$display("[FAIL] %s prg_dout expected %h actual %h", chk_name, exp_dout, prg_dout);
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, %0d checks run, %0d errors", LIMIT, checks, errors);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		arst_n    = 1'b0;
		ce        = 1'b1;
		prg_ain   = '0;
		prg_write = 1'b0;
		prg_din   = '0;
		chk_mask  = '0;
		errors    = 0;
		checks    = 0;
		rng_state = 32'd58;
		test_name = "idle";
		model_reset();
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		verify_reset_state();
		sweep_prg_modes();
		exercise_protection();
		cycle_exram_modes();
		multiply_pairs();
		bus_cycle(16'h0000, 1'b0, 8'h00, 3'b000); // Let the last compare run
		bus_cycle(16'h0000, 1'b0, 8'h00, 3'b000);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: mmc5.f
+incdir+bench
rtl/mmc5_map_pkg.sv
rtl/mmc5_cfg_pkg.sv
rtl/mmc5_cfg_if.sv
rtl/mmc5_reg_file.sv
rtl/mmc5_exram.sv
rtl/mmc5_prg_port.sv
rtl/mmc5.sv
bench/mmc5_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f mmc5.f --top-module mmc5_tb -o mmc5_sim \
	&& ./obj_dir/mmc5_sim | tee sim.log \
	|| echo "Build or simulation did not complete"
grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
